// File: include/rvseed_config.svh
`ifndef RVSEED_CONFIG_SVH
`define RVSEED_CONFIG_SVH

// integer data path, fixed by RV64
`define RV_XLEN 64

// architectural register file
`define RV_REG_ADDR_WIDTH 5
`define RV_REG_COUNT 32

// encoded width of alu_op_e
`define RV_ALU_OP_WIDTH 4

`endif

// File: verilog/rvseed_pkg.sv
`include "rvseed_config.svh"

package rvseed_pkg;

    // major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate

    typedef struct packed {
        logic [6:0]                    funct7;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs2;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                    funct3;
        logic [`RV_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                    opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0]                   imm12;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                    funct3;
        logic [`RV_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                    opcode;
    } rv_i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
    } rv_instr_u;

    typedef enum logic [`RV_ALU_OP_WIDTH-1:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_e;

endpackage

// File: verilog/intake_fsm.sv
`timescale 1ns/100ps

module intake_fsm import rvseed_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_req_i,
    input  logic [31:0] instr_i,
    output logic        instr_ack_o,
    output rv_instr_u   instr_o,
    output logic        dec_valid_o
);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] CAPTURE  = 2'd1;
    localparam logic [1:0] WAIT_LOW = 2'd2;

    logic [1:0] state;
    logic       take;

    assign take = (state == IDLE) && instr_req_i; // capture edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            instr_ack_o <= 1'b0;
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= take; // one cycle, the decode cycle
            case (state)
                IDLE: begin
                    if (instr_req_i) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    instr_ack_o <= 1'b1; // req still high here
                    state       <= WAIT_LOW;
                end
                WAIT_LOW: begin
                    if (!instr_req_i) begin
                        instr_ack_o <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: begin
                    instr_ack_o <= 1'b0;
                    state       <= IDLE;
                end
            endcase
        end
    end

    // word stays put until the next handshake
    always_ff @(posedge clk) begin
        if (take) begin
            instr_o <= instr_i;
        end
    end

endmodule

// File: verilog/id_decode.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module id_decode import rvseed_pkg::*; (
    input  rv_instr_u                     instr_i,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_o,
    output alu_op_e                       alu_op_o,
    output logic                          use_imm_o,
    output logic [`RV_XLEN-1:0]           imm_o,
    output logic                          illegal_o
);

    always_comb begin
        // register fields sit at the same bits in both layouts
        rs1_addr_o = instr_i.r.rs1;
        rs2_addr_o = instr_i.r.rs2;
        rd_addr_o  = instr_i.r.rd;
        imm_o      = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
        alu_op_o   = ALU_ADD;
        use_imm_o  = 1'b0;
        illegal_o  = 1'b0;

        case (instr_i.r.opcode)
            OPC_OP: begin
                case ({instr_i.r.funct7[5], instr_i.r.funct3})
                    4'b0_000: alu_op_o = ALU_ADD;
                    4'b1_000: alu_op_o = ALU_SUB;
                    4'b0_001: alu_op_o = ALU_SLL;
                    4'b0_100: alu_op_o = ALU_XOR;
                    4'b0_101: alu_op_o = ALU_SRL;
                    4'b0_110: alu_op_o = ALU_OR;
                    4'b0_111: alu_op_o = ALU_AND;
                    default:  illegal_o = 1'b1; // slt, sltu, sra and friends
                endcase
                // only funct7 bit 5 may be set
                if (instr_i.r.funct7[6] || (|instr_i.r.funct7[4:0])) begin
                    illegal_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                case (instr_i.i.funct3)
                    3'b000:  alu_op_o = ALU_ADD;
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b110:  alu_op_o = ALU_OR;
                    3'b111:  alu_op_o = ALU_AND;
                    default: illegal_o = 1'b1; // immediate shifts, slti
                endcase
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]           rs1_data_o,
    output logic [`RV_XLEN-1:0]           rs2_data_o,
    input  logic                          we_i,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]           wdata_i
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    logic                wr_live;

    assign wr_live = we_i && (waddr_i != '0); // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous reads
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// File: verilog/id_ex_regs.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module id_ex_regs import rvseed_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_i,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  alu_op_e                       alu_op_i,
    input  logic                          use_imm_i,
    input  logic [`RV_XLEN-1:0]           imm_i,
    input  logic                          illegal_i,
    input  logic [`RV_XLEN-1:0]           rs1_data_i,
    input  logic [`RV_XLEN-1:0]           rs2_data_i,
    output logic                          valid_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_o,
    output alu_op_e                       alu_op_o,
    output logic                          use_imm_o,
    output logic [`RV_XLEN-1:0]           imm_o,
    output logic                          illegal_o,
    output logic [`RV_XLEN-1:0]           rs1_data_o,
    output logic [`RV_XLEN-1:0]           rs2_data_o
);

    // bubble when nothing was decoded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // fields only move with a real instruction, hold otherwise
    always_ff @(posedge clk) begin
        if (valid_i) begin
            rd_addr_o  <= rd_addr_i;
            alu_op_o   <= alu_op_i;
            use_imm_o  <= use_imm_i;
            imm_o      <= imm_i;
            illegal_o  <= illegal_i;
            rs1_data_o <= rs1_data_i;
            rs2_data_o <= rs2_data_i;
        end
    end

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module ex_alu import rvseed_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_i,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  alu_op_e                       alu_op_i,
    input  logic                          use_imm_i,
    input  logic [`RV_XLEN-1:0]           imm_i,
    input  logic                          illegal_i,
    input  logic [`RV_XLEN-1:0]           rs1_data_i,
    input  logic [`RV_XLEN-1:0]           rs2_data_i,
    output logic                          rd_we_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [`RV_XLEN-1:0]           rd_data_o,
    output logic                          illegal_o,
    output logic                          retire_o
);

    logic [`RV_XLEN-1:0] op_b;
    logic [5:0]          shamt;
    logic [`RV_XLEN-1:0] result;

    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[5:0]; // RV64 shift amount

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result = rs1_data_i + op_b;
            ALU_SUB: result = rs1_data_i - op_b;
            ALU_AND: result = rs1_data_i & op_b;
            ALU_OR:  result = rs1_data_i | op_b;
            ALU_XOR: result = rs1_data_i ^ op_b;
            ALU_SLL: result = rs1_data_i << shamt;
            ALU_SRL: result = rs1_data_i >> shamt; // logical
            default: result = '0;
        endcase
    end

    // writeback strobes, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_we_o   <= 1'b0;
            illegal_o <= 1'b0;
            retire_o  <= 1'b0;
        end else begin
            rd_we_o   <= valid_i && !illegal_i && (rd_addr_i != '0);
            illegal_o <= valid_i && illegal_i;
            retire_o  <= valid_i; // legal or not
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            rd_addr_o <= rd_addr_i;
            rd_data_o <= result;
        end
    end

endmodule

// File: verilog/retire_counter.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module retire_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                retire_i,
    output logic [`RV_XLEN-1:0] count_o
);

    // 64 bits, wrap is out of reach
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (retire_i) begin
            count_o <= count_o + 1'b1;
        end
    end

endmodule

// File: verilog/rvseed_core.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module rvseed_core import rvseed_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_req_i,
    input  logic [31:0]                   instr_i,
    output logic                          instr_ack_o,
    output logic                          rd_we_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [`RV_XLEN-1:0]           rd_data_o,
    output logic                          illegal_o,
    output logic [`RV_XLEN-1:0]           retired_o
);

    rv_instr_u                     instr_q;
    logic                          dec_valid;
    logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr, dec_rd_addr;
    alu_op_e                       dec_alu_op;
    logic                          dec_use_imm, dec_illegal;
    logic [`RV_XLEN-1:0]           dec_imm, rs1_data, rs2_data;

    logic                          ex_valid;
    logic [`RV_REG_ADDR_WIDTH-1:0] ex_rd_addr;
    alu_op_e                       ex_alu_op;
    logic                          ex_use_imm, ex_illegal;
    logic [`RV_XLEN-1:0]           ex_imm, ex_rs1_data, ex_rs2_data;
    logic                          retire;

    intake_fsm u_intake_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_o (instr_ack_o),
        .instr_o     (instr_q),
        .dec_valid_o (dec_valid)
    );

    id_decode u_id_decode (
        .instr_i    (instr_q),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (dec_rd_addr),
        .alu_op_o   (dec_alu_op),
        .use_imm_o  (dec_use_imm),
        .imm_o      (dec_imm),
        .illegal_o  (dec_illegal)
    );

    // written straight from the writeback strobe
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rd_we_o),
        .waddr_i    (rd_addr_o),
        .wdata_i    (rd_data_o)
    );

    id_ex_regs u_id_ex_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (dec_valid),
        .rd_addr_i  (dec_rd_addr),
        .alu_op_i   (dec_alu_op),
        .use_imm_i  (dec_use_imm),
        .imm_i      (dec_imm),
        .illegal_i  (dec_illegal),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .valid_o    (ex_valid),
        .rd_addr_o  (ex_rd_addr),
        .alu_op_o   (ex_alu_op),
        .use_imm_o  (ex_use_imm),
        .imm_o      (ex_imm),
        .illegal_o  (ex_illegal),
        .rs1_data_o (ex_rs1_data),
        .rs2_data_o (ex_rs2_data)
    );

    ex_alu u_ex_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (ex_valid),
        .rd_addr_i  (ex_rd_addr),
        .alu_op_i   (ex_alu_op),
        .use_imm_i  (ex_use_imm),
        .imm_i      (ex_imm),
        .illegal_i  (ex_illegal),
        .rs1_data_i (ex_rs1_data),
        .rs2_data_i (ex_rs2_data),
        .rd_we_o    (rd_we_o),
        .rd_addr_o  (rd_addr_o),
        .rd_data_o  (rd_data_o),
        .illegal_o  (illegal_o),
        .retire_o   (retire)
    );

    retire_counter u_retire_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire_i (retire),
        .count_o  (retired_o)
    );

endmodule

// File: verif/rvseed_checker.sv
`timescale 1ns/100ps

module rvseed_checker (
    input logic clk,
    input logic rst_n,
    input logic instr_req_i,
    input logic instr_ack_i,
    input logic rd_we_i,
    input logic illegal_i
);

    int assert_errs = 0;

    // ack answers a pending request only
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack_i) |-> $past(instr_req_i))
        else begin
            $error("instr_ack_o rose while instr_req_i was low");
            assert_errs++;
        end

    // four-phase return to zero
    ack_fall_after_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(instr_ack_i) |-> !$past(instr_req_i))
        else begin
            $error("instr_ack_o fell while instr_req_i was still high");
            assert_errs++;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_we_i && illegal_i))
        else begin
            $error("rd_we_o and illegal_o high in the same cycle");
            assert_errs++;
        end

    write_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_we_i |=> !rd_we_i)
        else begin
            $error("rd_we_o held for more than one cycle");
            assert_errs++;
        end

    illegal_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_i |=> !illegal_i)
        else begin
            $error("illegal_o held for more than one cycle");
            assert_errs++;
        end

endmodule

// File: verif/rvseed_monitor.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module rvseed_monitor import rvseed_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_ack_i,
    input  logic                          rd_we_i,
    input  logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic [`RV_XLEN-1:0]           rd_data_i,
    input  logic                          illegal_i,
    input  logic [`RV_XLEN-1:0]           retired_i,
    output int                            retired_seen_o,
    output int                            check_cnt_o,
    output int                            err_cnt_o
);

    logic [`RV_XLEN-1:0]           model [`RV_REG_COUNT];
    rv_instr_u                     issued_q [$];
    rv_instr_u                     cur;
    logic                          ack_q = 1'b0;
    logic                          strobe_due = 1'b0; // strobe expected this sample
    logic                          count_due = 1'b0;
    logic                          exp_legal;
    logic [`RV_REG_ADDR_WIDTH-1:0] exp_rd;
    logic [`RV_XLEN-1:0]           exp_data;
    logic [`RV_XLEN-1:0]           exp_retired = '0;
    int                            retired_seen = 0;
    int                            check_cnt = 0;
    int                            err_cnt = 0;

    assign retired_seen_o = retired_seen;
    assign check_cnt_o    = check_cnt;
    assign err_cnt_o      = err_cnt;

    // reference semantics of the supported RV64 subset
    function automatic logic predict_result(input rv_instr_u w, input logic [63:0] a,
                                            input logic [63:0] b, output logic [63:0] res);
        logic [63:0] imm;
        logic        legal;
        imm   = {{52{w.i.imm12[11]}}, w.i.imm12};
        legal = 1'b1;
        res   = '0;
        if (w.r.opcode == 7'b0110011) begin
            case ({w.r.funct7, w.r.funct3})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_001: res = a << b[5:0];
                10'b0000000_100: res = a ^ b;
                10'b0000000_101: res = a >> b[5:0];
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         legal = 1'b0;
            endcase
        end else if (w.i.opcode == 7'b0010011) begin
            case (w.i.funct3)
                3'b000:  res = a + imm;
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        return legal;
    endfunction

    task automatic push_word(input rv_instr_u w);
        issued_q.push_back(w);
    endtask

    task automatic check_final(input int handshakes);
        check_cnt++;
        if (retired_i !== 64'(handshakes)) begin
            err_cnt++;
            $display("** Error at %0t: retired_o is %0d after %0d handshakes",
                     $time, retired_i, handshakes);
        end
        if (issued_q.size() != 0) begin
            err_cnt++;
            $display("monitor: %0d issued words never reached a handshake", issued_q.size());
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                model[i] = '0;
            end
            ack_q       = 1'b0;
            strobe_due  = 1'b0;
            count_due   = 1'b0;
            exp_retired = '0;
        end else begin
            if (count_due) begin // counter lags the strobe by one edge
                check_cnt++;
                if (retired_i !== exp_retired) begin
                    err_cnt++;
                    $display("** Error at %0t: retired_o is %0d, expected %0d",
                             $time, retired_i, exp_retired);
                end
                retired_seen++;
                count_due = 1'b0;
            end
            if (strobe_due) begin
                check_cnt++;
                if (exp_legal && exp_rd != '0) begin
                    if (rd_we_i !== 1'b1 || illegal_i !== 1'b0 || rd_addr_i !== exp_rd ||
                        rd_data_i !== exp_data) begin
                        err_cnt++;
                        $display("** Error at %0t: write x%0d=%h we=%b, expected x%0d=%h",
                                 $time, rd_addr_i, rd_data_i, rd_we_i, exp_rd, exp_data);
                    end
                    model[exp_rd] = exp_data;
                end else if (exp_legal) begin
                    if (rd_we_i !== 1'b0 || illegal_i !== 1'b0) begin
                        err_cnt++;
                        $display("** Error at %0t: strobe for a write to x0", $time);
                    end
                end else if (illegal_i !== 1'b1 || rd_we_i !== 1'b0) begin
                    err_cnt++;
                    $display("** Error at %0t: illegal=%b we=%b for word %h, expected illegal",
                             $time, illegal_i, rd_we_i, cur);
                end
                strobe_due = 1'b0;
                count_due  = 1'b1;
            end else if (rd_we_i || illegal_i) begin
                err_cnt++;
                $display("** Error at %0t: strobe we=%b illegal=%b with nothing in flight",
                         $time, rd_we_i, illegal_i);
            end
            if (instr_ack_i && !ack_q) begin // ack rose, capture was one edge earlier
                if (issued_q.size() == 0) begin
                    err_cnt++;
                    $display("monitor: handshake at %0t with no issued word", $time);
                end else begin
                    cur         = issued_q.pop_front();
                    exp_legal   = predict_result(cur, model[cur.r.rs1], model[cur.r.rs2],
                                                 exp_data);
                    exp_rd      = cur.r.rd;
                    exp_retired = exp_retired + 1'b1;
                    strobe_due  = 1'b1;
                end
            end
            ack_q = instr_ack_i;
        end
    end

endmodule

// File: verif/rvseed_tb.sv
`timescale 1ns/100ps
`include "rvseed_config.svh"

module rvseed_tb import rvseed_pkg::*; ();

    localparam int         WAIT_LIMIT   = 100;
    localparam int         RANDOM_COUNT = 400;
    localparam logic [6:0] OPC_REG      = 7'b0110011;
    localparam logic [6:0] OPC_IMM      = 7'b0010011;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          instr_req;
    logic [31:0]                   instr_word;
    logic                          instr_ack;
    logic                          rd_we;
    logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr;
    logic [`RV_XLEN-1:0]           rd_data;
    logic                          illegal;
    logic [`RV_XLEN-1:0]           retired;
    integer                        seed;
    int                            issued;
    logic                          timed_out;
    int                            retired_seen;
    int                            check_cnt;
    int                            err_cnt;

    always #10 clk = ~clk;

    rvseed_core u_rvseed_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req),
        .instr_i     (instr_word),
        .instr_ack_o (instr_ack),
        .rd_we_o     (rd_we),
        .rd_addr_o   (rd_addr),
        .rd_data_o   (rd_data),
        .illegal_o   (illegal),
        .retired_o   (retired)
    );

    rvseed_monitor u_rvseed_monitor (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_ack_i    (instr_ack),
        .rd_we_i        (rd_we),
        .rd_addr_i      (rd_addr),
        .rd_data_i      (rd_data),
        .illegal_i      (illegal),
        .retired_i      (retired),
        .retired_seen_o (retired_seen),
        .check_cnt_o    (check_cnt),
        .err_cnt_o      (err_cnt)
    );

    bind rvseed_core rvseed_checker u_rvseed_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req_i),
        .instr_ack_i (instr_ack_o),
        .rd_we_i     (rd_we_o),
        .illegal_i   (illegal_o)
    );

    task automatic next_cycle();
        @(posedge clk);
        #2; // drive point
    endtask

    function automatic rv_instr_u make_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        rv_instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = OPC_REG;
        return w;
    endfunction

    function automatic rv_instr_u make_i(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1);
        rv_instr_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = OPC_IMM;
        return w;
    endfunction

    function automatic rv_instr_u random_word();
        int         sel;
        int         pick;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        rv_instr_u  w;
        sel  = $unsigned($random(seed)) % 10;
        pick = $unsigned($random(seed)) % 7;
        rd   = $random(seed);
        rs1  = $random(seed);
        rs2  = $random(seed);
        if (($unsigned($random(seed)) % 8) == 0) begin
            rd = 5'd0; // extra x0 targets
        end
        f7 = (pick == 1) ? 7'b0100000 : 7'b0000000; // sub
        case (pick)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b001;
            3:       f3 = 3'b100;
            4:       f3 = 3'b101;
            5:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        if (sel < 5) begin
            w = make_r(f7, f3, rd, rs1, rs2);
        end else if (sel < 8) begin
            case (pick % 4)
                0:       f3 = 3'b000; // addi
                1:       f3 = 3'b100; // xori
                2:       f3 = 3'b110; // ori
                default: f3 = 3'b111; // andi
            endcase
            w = make_i($random(seed), f3, rd, rs1);
        end else if (sel == 8) begin
            w = make_r($random(seed), $random(seed), rd, rs1, rs2); // mostly bad funct
        end else begin
            w = $random(seed);
        end
        return w;
    endfunction

    task automatic wait_ack(input logic level, output logic ok);
        int t;
        t = 0;
        while (instr_ack !== level && t < WAIT_LIMIT) begin
            next_cycle();
            t++;
        end
        ok = (instr_ack === level);
        if (!ok) begin
            $display("rvseed_tb: instr_ack_o did not go to %0b within %0d cycles, handshake hung",
                     level, WAIT_LIMIT);
        end
    endtask

    task automatic issue(input rv_instr_u w);
        int   gap;
        logic ok;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) next_cycle();
        u_rvseed_monitor.push_word(w);
        instr_word = w;
        instr_req  = 1'b1;
        wait_ack(1'b1, ok);
        if (ok) begin
            instr_req = 1'b0;
            wait_ack(1'b0, ok);
        end
        if (ok) begin
            issued++;
        end else begin
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain(output logic ok);
        int t;
        t = 0;
        while (retired_seen < issued && t < WAIT_LIMIT) begin
            next_cycle();
            t++;
        end
        ok = (retired_seen >= issued);
        if (!ok) begin
            $display("rvseed_tb: only %0d of %0d instructions retired before the time limit",
                     retired_seen, issued);
        end
    endtask

    initial begin
        int   n;
        logic ok;
        int   assert_errs;
        rst_n      = 1'b0;
        instr_req  = 1'b0;
        instr_word = '0;
        seed       = 32'h483c;
        issued     = 0;
        timed_out  = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        // known contents first, addi xN, x0, imm
        for (n = 1; n < `RV_REG_COUNT && !timed_out; n++) begin
            issue(make_i($random(seed), 3'b000, n[4:0], 5'd0));
        end
        for (n = 0; n < RANDOM_COUNT && !timed_out; n++) begin
            issue(random_word());
        end
        if (!timed_out) begin
            wait_drain(ok);
            timed_out = !ok;
        end
        if (!timed_out) begin
            u_rvseed_monitor.check_final(issued);
        end
        #1;
        assert_errs = u_rvseed_core.u_rvseed_checker.assert_errs;
        $display("%0d handshakes, %0d checks, %0d errors, %0d assertion failures, %0d timeouts",
                 issued, check_cnt, err_cnt, assert_errs, timed_out);
        if (err_cnt == 0 && assert_errs == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/rvseed_pkg.sv
verilog/intake_fsm.sv
verilog/id_decode.sv
verilog/reg_file.sv
verilog/id_ex_regs.sv
verilog/ex_alu.sv
verilog/retire_counter.sv
verilog/rvseed_core.sv
verif/rvseed_checker.sv
verif/rvseed_monitor.sv
verif/rvseed_tb.sv

// File: Bender.yml
package:
  name: rvseed

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rvseed_pkg.sv
      - verilog/intake_fsm.sv
      - verilog/id_decode.sv
      - verilog/reg_file.sv
      - verilog/id_ex_regs.sv
      - verilog/ex_alu.sv
      - verilog/retire_counter.sv
      - verilog/rvseed_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rvseed_checker.sv
      - verif/rvseed_monitor.sv
      - verif/rvseed_tb.sv
